// ==== cpuTop.f ====
hdl/cpuIsaPkg.sv
hdl/panelPkg.sv
hdl/panelCmdIf.sv
hdl/coreStatusIf.sv
hdl/keyDebouncer.sv
hdl/commandDecoder.sv
hdl/programBuffer.sv
hdl/cpuCore.sv
hdl/displayDriver.sv
hdl/cpuTop.sv
sim/cpuTopTb.sv

// ==== hdl/commandDecoder.sv ====
`timescale 1ns/1ps

module commandDecoder
#(
    parameter int debounceCycles = panelPkg::defaultDebounce
)
(
    input  logic         clk18,
    input  logic         reset,
    input  logic [3:0]   key,
    input  logic         clearKey,
    input  logic [9:0]   sw,
    panelCmdIf.decoder   cmd,
    coreStatusIf.decoder status
);
    import panelPkg::*;

    logic [4:0] keyN;                           // clear key on top
    logic [4:0] press;
    panelMode_t mode;
    logic       accept;

    assign keyN   = {clearKey, key};
    assign mode   = panelMode_t'(sw[0]);
    assign accept = !status.busy && !cmd.run;   // core goes busy on the edge after run

    for (genvar i = 0; i < 5; i++)
    begin : gKey
        keyDebouncer #(.debounceCycles(debounceCycles)) i_keyDebouncer
        (
            .clk18 (clk18),
            .reset (reset),
            .keyN  (keyN[i]),
            .press (press[i])
        );
    end

    // priority chain keeps the outputs one-hot if keys land together
    always_ff @(posedge clk18)
    begin
        if (reset)
        begin
            cmd.write       <= 1'b0;
            cmd.forward     <= 1'b0;
            cmd.back        <= 1'b0;
            cmd.insert      <= 1'b0;
            cmd.delete      <= 1'b0;
            cmd.run         <= 1'b0;
            cmd.clearCursor <= 1'b0;
            cmd.clearAll    <= 1'b0;
        end
        else
        begin
            cmd.write       <= 1'b0;
            cmd.forward     <= 1'b0;
            cmd.back        <= 1'b0;
            cmd.insert      <= 1'b0;
            cmd.delete      <= 1'b0;
            cmd.run         <= 1'b0;
            cmd.clearCursor <= 1'b0;
            cmd.clearAll    <= 1'b0;
            if (accept && mode == modeEdit)
            begin
                if (press[4])
                    cmd.clearCursor <= 1'b1;
                else if (press[0])
                    cmd.write <= 1'b1;
                else if (press[1])
                    cmd.forward <= 1'b1;
                else if (press[2])
                    cmd.back <= 1'b1;
            end
            else if (accept)
            begin
                if (press[4])
                    cmd.clearAll <= 1'b1;
                else if (press[1])
                    cmd.insert <= 1'b1;
                else if (press[2])
                    cmd.delete <= 1'b1;
                else if (press[3])
                    cmd.run <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk18)
    begin
        cmd.writeData <= sw[9:2];               // lines up with the write pulse
    end

    assert property (@(posedge clk18) disable iff (reset)
        $onehot0({cmd.write, cmd.forward, cmd.back, cmd.insert, cmd.delete, cmd.run,
                  cmd.clearCursor, cmd.clearAll}));

endmodule

// ==== hdl/coreStatusIf.sv ====
`timescale 1ns/1ps

interface coreStatusIf;
    import cpuIsaPkg::*;

    logic                 busy;                 // high for the whole run
    logic                 timedOut;             // run stopped by the step limit
    logic [wordWidth-1:0] acc;
    logic [addrWidth-1:0] pc;

    modport core (output busy, timedOut, acc, pc);
    modport decoder (input busy);
    modport display (input busy, timedOut, acc, pc);

endinterface

// ==== hdl/cpuCore.sv ====
`timescale 1ns/1ps

module cpuCore
(
    input  logic                            clk18,
    input  logic                            reset,
    panelCmdIf.core                         cmd,
    coreStatusIf.core                       status,
    output logic [cpuIsaPkg::addrWidth-1:0] fetchAddr,
    input  logic [cpuIsaPkg::wordWidth-1:0] fetchData,
    input  logic [cpuIsaPkg::addrWidth:0]   length
);
    import cpuIsaPkg::*;

    logic                                 busy;
    logic                                 timedOut;
    logic [wordWidth-1:0]                 acc;
    logic [addrWidth-1:0]                 pc;
    logic [$clog2(stepLimit + 1)-1:0]     stepCount;
    opcode_t                              opcode;
    logic [wordWidth-1:0]                 imm;
    logic [addrWidth-1:0]                 target;
    logic [addrWidth:0]                   pcNext;  // extra bit flags running off the buffer
    logic                                 atEnd;
    logic                                 lastStep;

    assign opcode   = opcode_t'(fetchData[wordWidth-1:immWidth]);
    assign imm      = wordWidth'(fetchData[immWidth-1:0]);
    assign target   = addrWidth'(fetchData[immWidth-1:0]);
    assign atEnd    = {1'b0, pc} >= length;
    assign lastStep = int'(stepCount) == stepLimit - 1;

    always_comb
    begin
        pcNext = {1'b0, pc} + 1'b1;
        case (opcode)
            opJmp:
                pcNext = {1'b0, target};
            opJz:
            begin
                if (acc == '0)
                    pcNext = {1'b0, target};
            end
            opHalt:
                pcNext = {1'b0, pc};            // parks on the halt
            default:
                ;
        endcase
    end

    always_ff @(posedge clk18)
    begin
        if (reset)
        begin
            busy      <= 1'b0;
            timedOut  <= 1'b0;
            acc       <= '0;
            pc        <= '0;
            stepCount <= '0;
        end
        else if (!busy)
        begin
            if (cmd.run)
            begin
                busy      <= 1'b1;
                timedOut  <= 1'b0;
                acc       <= '0;
                pc        <= '0;
                stepCount <= '0;
            end
        end
        else if (atEnd)
            busy <= 1'b0;                       // fell off the program, nothing executed
        else
        begin
            stepCount <= stepCount + 1'b1;
            pc        <= pcNext[addrWidth-1:0];
            case (opcode)
                opLdi:   acc <= imm;
                opAddi:  acc <= acc + imm;
                opSubi:  acc <= acc - imm;
                opXori:  acc <= acc ^ imm;
                default: ;
            endcase
            if (opcode == opHalt)
                busy <= 1'b0;
            else if (lastStep)
            begin
                busy     <= 1'b0;
                timedOut <= 1'b1;
            end
            else if (pcNext[addrWidth])
                busy <= 1'b0;                   // stepped past entry 127
        end
    end

    assign fetchAddr       = pc;
    assign status.busy     = busy;
    assign status.timedOut = timedOut;
    assign status.acc      = acc;
    assign status.pc       = pc;

    // every fetch inside the program hits an entry the buffer has filled
    assert property (@(posedge clk18) disable iff (reset)
        busy && !atEnd |-> !$isunknown(fetchData));

endmodule

// ==== hdl/cpuIsaPkg.sv ====
package cpuIsaPkg;

    localparam int wordWidth = 8;               // instruction and accumulator
    localparam int addrWidth = 7;               // program buffer address
    localparam int bufDepth  = 128;
    localparam int immWidth  = 5;               // low bits of an instruction
    localparam int opWidth   = wordWidth - immWidth;

    // top three bits of an instruction
    typedef enum logic [opWidth-1:0]
    {
        opNop  = 3'd0,                          // pc+1 only
        opLdi  = 3'd1,                          // acc = imm
        opAddi = 3'd2,                          // acc + imm, wraps
        opSubi = 3'd3,                          // acc - imm, wraps
        opXori = 3'd4,
        opJmp  = 3'd5,                          // pc = imm
        opJz   = 3'd6,                          // jump when acc is zero
        opHalt = 3'd7
    } opcode_t;

    // filler put in by an insert
    localparam logic [wordWidth-1:0] nopWord = {opNop, {immWidth{1'b0}}};

    localparam int stepLimit = 255;             // executed instructions per run

endpackage

// ==== hdl/cpuTop.sv ====
`timescale 1ns/1ps

module cpuTop
#(
    parameter int debounceCycles = panelPkg::defaultDebounce
)
(
    input  logic       clk18,
    input  logic       reset,
    input  logic [3:0] key,                     // active low
    input  logic       clearKey,                // active low
    input  logic [9:0] sw,
    output logic [6:0] hex0,
    output logic [6:0] hex1,
    output logic [6:0] hex2,
    output logic [6:0] hex3,
    output logic [7:0] ledg,
    output logic [9:0] ledr
);
    import cpuIsaPkg::*;

    logic [addrWidth-1:0] fetchAddr;
    logic [wordWidth-1:0] fetchData;
    logic [addrWidth:0]   length;               // 0 to 128
    logic [addrWidth-1:0] cursor;
    logic [wordWidth-1:0] cursorData;

    panelCmdIf   cmdBus ();
    coreStatusIf statusBus ();

    commandDecoder #(.debounceCycles(debounceCycles)) i_commandDecoder
    (
        .clk18    (clk18),
        .reset    (reset),
        .key      (key),
        .clearKey (clearKey),
        .sw       (sw),
        .cmd      (cmdBus.decoder),
        .status   (statusBus.decoder)
    );

    programBuffer i_programBuffer
    (
        .clk18      (clk18),
        .reset      (reset),
        .cmd        (cmdBus.buffer),
        .fetchAddr  (fetchAddr),
        .fetchData  (fetchData),
        .length     (length),
        .cursor     (cursor),
        .cursorData (cursorData)
    );

    cpuCore i_cpuCore
    (
        .clk18     (clk18),
        .reset     (reset),
        .cmd       (cmdBus.core),
        .status    (statusBus.core),
        .fetchAddr (fetchAddr),
        .fetchData (fetchData),
        .length    (length)
    );

    displayDriver i_displayDriver
    (
        .clk18      (clk18),
        .reset      (reset),
        .sw         (sw),
        .key        (key),
        .status     (statusBus.display),
        .cursor     (cursor),
        .cursorData (cursorData),
        .length     (length),
        .hex0       (hex0),
        .hex1       (hex1),
        .hex2       (hex2),
        .hex3       (hex3),
        .ledg       (ledg),
        .ledr       (ledr)
    );

endmodule

// ==== hdl/displayDriver.sv ====
`timescale 1ns/1ps

module displayDriver
(
    input  logic                            clk18,
    input  logic                            reset,
    input  logic [9:0]                      sw,
    input  logic [3:0]                      key,
    coreStatusIf.display                    status,
    input  logic [cpuIsaPkg::addrWidth-1:0] cursor,
    input  logic [cpuIsaPkg::wordWidth-1:0] cursorData,
    input  logic [cpuIsaPkg::addrWidth:0]   length,
    output logic [6:0]                      hex0,
    output logic [6:0]                      hex1,
    output logic [6:0]                      hex2,
    output logic [6:0]                      hex3,
    output logic [7:0]                      ledg,
    output logic [9:0]                      ledr
);
    import cpuIsaPkg::*;
    import panelPkg::*;

    logic [blinkBit:0]    blinkCnt;
    panelMode_t           mode;
    logic [wordWidth-1:0] lowByte;              // hex1:0
    logic [wordWidth-1:0] highByte;             // hex3:2
    logic                 blank;

    always_ff @(posedge clk18)
    begin
        if (reset)
            blinkCnt <= '0;
        else
            blinkCnt <= blinkCnt + 1'b1;
    end

    assign mode = panelMode_t'(sw[0]);

    // a held key keeps the digits lit so the operator sees them
    assign blank = (length == '0) && blinkCnt[blinkBit] && (&key);

    always_comb
    begin
        if (mode == modeEdit)
        begin
            lowByte  = sw[9:2];
            highByte = sw[1] ? wordWidth'(cursor) : cursorData;
            ledr     = {sw[9:2], sw[1], sw[0]};
            ledg     = {1'b0, cursor};
        end
        else
        begin
            lowByte  = status.acc;
            highByte = wordWidth'(status.pc);
            ledr     = {status.acc, status.timedOut, sw[0]};
            ledg     = {status.busy, status.pc};
        end
    end

    assign hex0 = segPattern[lowByte[3:0]];
    assign hex1 = segPattern[lowByte[7:4]];
    assign hex2 = blank ? segBlank : segPattern[highByte[3:0]];
    assign hex3 = blank ? segBlank : segPattern[highByte[7:4]];

endmodule

// ==== hdl/keyDebouncer.sv ====
`timescale 1ns/1ps

module keyDebouncer
#(
    parameter int debounceCycles = panelPkg::defaultDebounce
)
(
    input  logic clk18,
    input  logic reset,
    input  logic keyN,
    output logic press
);

    logic                                  syncMeta;
    logic                                  syncKeyN;
    logic [$clog2(debounceCycles + 1)-1:0] stableCnt;
    logic                                  waitRelease;   // pulse given, key still down

    always_ff @(posedge clk18)
    begin
        if (reset)
        begin
            syncMeta    <= 1'b1;                // keys idle high
            syncKeyN    <= 1'b1;
            stableCnt   <= '0;
            waitRelease <= 1'b0;
            press       <= 1'b0;
        end
        else
        begin
            syncMeta <= keyN;
            syncKeyN <= syncMeta;
            press    <= 1'b0;
            if (syncKeyN)
            begin
                stableCnt   <= '0;              // any bounce restarts the count
                waitRelease <= 1'b0;
            end
            else if (!waitRelease)
            begin
                if (int'(stableCnt) == debounceCycles - 1)
                begin
                    press       <= 1'b1;
                    waitRelease <= 1'b1;
                    stableCnt   <= '0;
                end
                else
                    stableCnt <= stableCnt + 1'b1;
            end
        end
    end

    assert property (@(posedge clk18) disable iff (reset) press |=> !press);

endmodule

// ==== hdl/panelCmdIf.sv ====
`timescale 1ns/1ps

interface panelCmdIf;
    import cpuIsaPkg::*;

    logic                 write;
    logic                 forward;
    logic                 back;
    logic                 insert;
    logic                 delete;
    logic                 run;
    logic                 clearCursor;
    logic                 clearAll;
    logic [wordWidth-1:0] writeData;            // byte stored by write

    modport decoder (output write, forward, back, insert, delete, run, clearCursor,
                     clearAll, writeData);
    modport buffer (input write, forward, back, insert, delete, clearCursor, clearAll,
                    writeData);
    modport core (input run);

endinterface

// ==== hdl/panelPkg.sv ====
package panelPkg;

    // switch 0 picks the mode
    typedef enum logic
    {
        modeRun  = 1'b0,
        modeEdit = 1'b1
    } panelMode_t;

    localparam int defaultDebounce = 10800;     // stable-low cycles per press
    localparam int blinkBit        = 23;        // blink counter bit for empty program

    localparam logic [6:0] segBlank = 7'h7f;    // all segments dark

    // active-low segments gfedcba, indexed by nibble
    localparam logic [6:0] segPattern [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30,
        7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03,
        7'h46, 7'h21, 7'h06, 7'h0e
    };

endpackage

// ==== hdl/programBuffer.sv ====
`timescale 1ns/1ps

module programBuffer
(
    input  logic                            clk18,
    input  logic                            reset,
    panelCmdIf.buffer                       cmd,
    input  logic [cpuIsaPkg::addrWidth-1:0] fetchAddr,
    output logic [cpuIsaPkg::wordWidth-1:0] fetchData,
    output logic [cpuIsaPkg::addrWidth:0]   length,
    output logic [cpuIsaPkg::addrWidth-1:0] cursor,
    output logic [cpuIsaPkg::wordWidth-1:0] cursorData
);
    import cpuIsaPkg::*;

    logic [wordWidth-1:0] mem [bufDepth];
    logic [addrWidth:0]   cursorInc;
    logic                 cursorInside;         // cursor on a used entry
    logic                 cursorAtTop;
    logic                 notFull;

    assign cursorInc    = {1'b0, cursor} + 1'b1;
    assign cursorInside = {1'b0, cursor} < length;
    assign cursorAtTop  = cursorInc[addrWidth];  // cursor is 127
    assign notFull      = !length[addrWidth];    // length never exceeds 128

    assign fetchData  = mem[fetchAddr];
    assign cursorData = mem[cursor];

    always_ff @(posedge clk18)
    begin
        if (cmd.write)
            mem[cursor] <= cmd.writeData;
        else if (cmd.insert && notFull)
        begin
            for (int i = bufDepth - 1; i > 0; i--)
            begin
                if (i > cursor)
                    mem[i] <= mem[i - 1];       // open a gap at the cursor
            end
            mem[cursor] <= nopWord;
        end
        else if (cmd.delete && cursorInside)
        begin
            for (int i = 0; i < bufDepth - 1; i++)
            begin
                if (i >= cursor)
                    mem[i] <= mem[i + 1];
            end
        end
    end

    always_ff @(posedge clk18)
    begin
        if (reset)
        begin
            cursor <= '0;
            length <= '0;
        end
        else if (cmd.write)
        begin
            if (!cursorInside)
                length <= cursorInc;            // writing past the end grows the program
            if (!cursorAtTop)
                cursor <= cursorInc[addrWidth-1:0];
        end
        else if (cmd.forward)
        begin
            if (cursorInside && !cursorAtTop)
                cursor <= cursorInc[addrWidth-1:0];
        end
        else if (cmd.back)
        begin
            if (cursor != '0)
                cursor <= cursor - 1'b1;
        end
        else if (cmd.insert)
        begin
            if (notFull)
                length <= length + 1'b1;
        end
        else if (cmd.delete)
        begin
            if (cursorInside)
                length <= length - 1'b1;
        end
        else if (cmd.clearCursor)
            cursor <= '0;
        else if (cmd.clearAll)
        begin
            cursor <= '0;
            length <= '0;
        end
    end

    assert property (@(posedge clk18) disable iff (reset) length <= bufDepth);
    assert property (@(posedge clk18) disable iff (reset)
        length != bufDepth |-> {1'b0, cursor} <= length);

endmodule

// ==== sim/cpuTopTb.sv ====
`timescale 1ns/1ps

module cpuTopTb;
    import cpuIsaPkg::*;

    // active-low segments gfedcba per nibble
    localparam logic [6:0] segTable [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30,
        7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03,
        7'h46, 7'h21, 7'h06, 7'h0e
    };

    logic        clk18;
    logic        reset;
    logic [3:0]  key;
    logic        clearKey;
    logic [9:0]  sw;
    logic [6:0]  hex0;
    logic [6:0]  hex1;
    logic [6:0]  hex2;
    logic [6:0]  hex3;
    logic [7:0]  ledg;
    logic [9:0]  ledr;

    logic [7:0]  mMem [128];                   // model buffer, unknown until written
    int          mCursor;
    int          mLength;
    logic [7:0]  mAcc;
    int          mPc;
    logic        mTimedOut;
    logic [7:0]  progQ [$];                     // program to be keyed in
    int          errorCount;
    int          timeoutCount;

    cpuTop #(.debounceCycles(4)) i_dut
    (
        .clk18    (clk18),
        .reset    (reset),
        .key      (key),
        .clearKey (clearKey),
        .sw       (sw),
        .hex0     (hex0),
        .hex1     (hex1),
        .hex2     (hex2),
        .hex3     (hex3),
        .ledg     (ledg),
        .ledr     (ledr)
    );

    initial clk18 = 1'b0;
    always #50 clk18 = ~clk18;

    function automatic logic [13:0] segPair(input logic [7:0] value);
        return {segTable[value[7:4]], segTable[value[3:0]]};
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            errorCount++;
            $display("ERROR %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    // idx 4 is the clear key
    task automatic pressKey(input int idx);
        @(posedge clk18);
        #5;
        if (idx == 4)
            clearKey = 1'b0;
        else
            key[idx] = 1'b0;
        repeat (10) @(posedge clk18);
        #5;
        key      = 4'hf;
        clearKey = 1'b1;
        repeat (10) @(posedge clk18);
        #5;
    endtask

    task automatic runModel();
        int      steps;
        opcode_t op;
        logic [7:0] imm;
        int      nextPc;
        mPc       = 0;
        mAcc      = 8'h00;
        mTimedOut = 1'b0;
        steps     = 0;
        while (mPc < mLength)
        begin
            op     = opcode_t'(mMem[mPc][7:5]);
            imm    = {3'b000, mMem[mPc][4:0]};
            nextPc = mPc + 1;
            steps++;
            case (op)
                opLdi:  mAcc = imm;
                opAddi: mAcc = mAcc + imm;
                opSubi: mAcc = mAcc - imm;
                opXori: mAcc = mAcc ^ imm;
                opJmp:  nextPc = imm;
                opJz:
                begin
                    if (mAcc == 8'h00)
                        nextPc = imm;
                end
                default: ;
            endcase
            if (op == opHalt)
                break;                          // pc stays on the halt
            mPc = nextPc % 128;
            if (steps == stepLimit)
            begin
                mTimedOut = 1'b1;
                break;
            end
            if (nextPc > 127)
                break;
        end
    endtask

    // model update first, then the key that makes the DUT do the same
    task automatic applyCommand(input string op);
        case (op)
            "write":
            begin
                mMem[mCursor] = sw[9:2];
                if (mCursor >= mLength)
                    mLength = mCursor + 1;
                if (mCursor < 127)
                    mCursor++;
                pressKey(0);
            end
            "forward":
            begin
                if (mCursor < mLength && mCursor < 127)
                    mCursor++;
                pressKey(1);
            end
            "back":
            begin
                if (mCursor > 0)
                    mCursor--;
                pressKey(2);
            end
            "insert":
            begin
                if (mLength < 128)
                begin
                    for (int i = 127; i > mCursor; i--)
                        mMem[i] = mMem[i - 1];
                    mMem[mCursor] = 8'h00;      // nop
                    mLength++;
                end
                pressKey(1);
            end
            "delete":
            begin
                if (mCursor < mLength)
                begin
                    for (int i = mCursor; i < 127; i++)
                        mMem[i] = mMem[i + 1];
                    mLength--;
                end
                pressKey(2);
            end
            "clearCursor":
            begin
                mCursor = 0;
                pressKey(4);
            end
            "clearAll":
            begin
                mCursor = 0;
                mLength = 0;
                pressKey(4);
            end
            "run":
            begin
                runModel();
                pressKey(3);
            end
            default: $display("unknown command %s requested", op);
        endcase
    endtask

    task automatic checkEdit();
        compare("ledg", ledg, 8'(mCursor));
        compare("ledr", ledr, sw);
        compare("hex1:0", {hex1, hex0}, segPair(sw[9:2]));
        if (sw[1])
            compare("hex3:2", {hex3, hex2}, segPair(8'(mCursor)));
        else if (!$isunknown(mMem[mCursor]))
            compare("hex3:2", {hex3, hex2}, segPair(mMem[mCursor]));
    endtask

    task automatic checkRun();
        compare("ledg", ledg, 8'(mPc));         // busy bit expected low
        compare("ledr", ledr, {mAcc, mTimedOut, 1'b0});
        compare("hex1:0", {hex1, hex0}, segPair(mAcc));
        compare("hex3:2", {hex3, hex2}, segPair(8'(mPc)));
    endtask

    task automatic waitIdle();
        int n;
        n = 0;
        while (ledg[7] !== 1'b0 && n < 2000)
        begin
            @(posedge clk18);
            #5;
            n++;
        end
        if (ledg[7] !== 1'b0)
        begin
            timeoutCount++;
            $display("timeout: core still busy after %0d cycles", n);
        end
    endtask

    task automatic loadProgram();
        sw[0] = 1'b0;
        applyCommand("clearAll");
        sw[1:0] = 2'b01;
        foreach (progQ[i])
        begin
            sw[9:2] = progQ[i];
            applyCommand("write");
        end
    endtask

    task automatic runAndCheck();
        sw[0] = 1'b0;
        applyCommand("run");
        waitIdle();
        checkRun();
    endtask

    // steps the cursor over the whole program in edit mode
    task automatic walkBuffer();
        sw[1:0] = 2'b01;
        applyCommand("clearCursor");
        checkEdit();
        repeat (mLength)
        begin
            applyCommand("forward");
            checkEdit();
        end
    endtask

    initial
    begin
        int      pick;
        int      progLen;
        opcode_t opChoice [6];
        void'($urandom(20));
        opChoice     = '{opLdi, opAddi, opSubi, opXori, opJz, opHalt};
        reset        = 1'b1;
        key          = 4'hf;
        clearKey     = 1'b1;
        sw           = 10'h001;
        mCursor      = 0;
        mLength      = 0;
        mAcc         = 8'h00;
        mPc          = 0;
        mTimedOut    = 1'b0;
        errorCount   = 0;
        timeoutCount = 0;
        repeat (2) @(posedge clk18);
        #5;
        reset = 1'b0;

        for (int i = 0; i < 8; i++)             // reset state, switches on the display
        begin
            sw = 10'($urandom) | 10'h001;
            @(posedge clk18);
            #5;
            checkEdit();
        end

        for (int i = 0; i < 40; i++)            // writes and cursor steps
        begin
            sw      = 10'($urandom) | 10'h001;
            pick    = $urandom % 4;
            sw[1]   = 1'b0;
            if (pick < 2)
                applyCommand("write");
            else if (pick == 2)
                applyCommand("forward");
            else
                applyCommand("back");
            sw[1] = 1'($urandom);
            @(posedge clk18);
            #5;
            checkEdit();
        end

        sw[0] = 1'b0;                           // insert and delete in run mode
        for (int i = 0; i < 12; i++)
            applyCommand(($urandom % 2) ? "insert" : "delete");
        walkBuffer();
        sw[0] = 1'b0;
        applyCommand("clearAll");
        applyCommand("delete");                 // empty program, nothing to remove
        sw[1:0] = 2'b01;
        @(posedge clk18);
        #5;
        checkEdit();
        applyCommand("forward");
        checkEdit();

        for (int p = 0; p < 6; p++)             // random programs
        begin
            progLen = 1 + $urandom % 12;
            progQ.delete();
            for (int i = 0; i < progLen; i++)
                progQ.push_back({opChoice[$urandom % 6], 5'($urandom)});
            loadProgram();
            runAndCheck();
        end

        progQ.delete();                         // endless loop hits the step limit
        progQ.push_back({opLdi, 5'($urandom)});
        progQ.push_back({opAddi, 5'($urandom)});
        progQ.push_back({opXori, 5'($urandom)});
        progQ.push_back({opJmp, 5'd1});
        loadProgram();
        runAndCheck();
        compare("ledr[1]", ledr[1], 1'b1);

        sw[0] = 1'b0;                           // keys during a run are dropped
        applyCommand("run");
        pressKey(4);
        pressKey(2);
        pressKey(1);
        compare("ledg[7]", ledg[7], 1'b1);
        waitIdle();
        checkRun();
        runAndCheck();
        walkBuffer();

        $display("errors: %0d mismatches, %0d timeouts", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule
